// File: project.f
+incdir+rtl
rtl/video_regs_pkg.sv
rtl/vram_bus_pkg.sv
rtl/video_dp_ram.sv
rtl/video_cpu_ctrl.sv
rtl/vram_arbiter.sv
rtl/video_line_fetch.sv
rtl/video_scanout.sv
rtl/video_top.sv
verif/video_sva.sv
verif/video_tb.sv

// File: Bender.yml
package:
  name: video_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/video_regs_pkg.sv
      - rtl/vram_bus_pkg.sv
      - rtl/video_dp_ram.sv
      - rtl/video_cpu_ctrl.sv
      - rtl/vram_arbiter.sv
      - rtl/video_line_fetch.sv
      - rtl/video_scanout.sv
      - rtl/video_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/video_sva.sv
      - verif/video_tb.sv

// File: verif/video_tb.sv
// Video controller testbench

`timescale 1ns/1ps
`include "video_macros.svh"

module video_tb import video_regs_pkg::*, vram_bus_pkg::*;;

	localparam vram_data_t READ_OFFSET = 32'h0000_0400;
	localparam vram_data_t PITCH       = 32'd16;
	localparam int         ROW_WORDS   = 4;
	localparam int         SKIP_X      = 8;
	localparam int         SKIP_Y      = 3;

	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_VBLANK,
		OP_HBLANK
	} op_e;

	// One row of the stimulus table.
	typedef struct packed {
		op_e         op;
		cpu_region_e region;
		logic [23:0] location;
		vram_data_t  data;
		vram_data_t  expected;
	} step_t;

	logic                     i_clock;
	logic                     i_rst_n;
	logic                     i_cpu_request;
	logic                     i_cpu_rw;
	logic [`VIDEO_DATA_W-1:0] i_cpu_address;
	logic [`VIDEO_DATA_W-1:0] i_cpu_wdata;
	logic [`VIDEO_DATA_W-1:0] o_cpu_rdata;
	logic                     o_cpu_ready;
	logic                     i_video_hblank;
	logic                     i_video_vblank;
	logic [`VIDEO_POS_W-1:0]  i_video_pos_x;
	logic [`VIDEO_POS_W-1:0]  i_video_pos_y;
	logic [`VIDEO_RGB_W-1:0]  o_video_rgb;
	logic                     o_vram_request;
	logic                     o_vram_rw;
	vram_addr_t               o_vram_address;
	vram_data_t               o_vram_wdata;
	vram_data_t               i_vram_rdata;
	logic                     i_vram_ready;

	step_t      steps[$];
	vram_data_t vram_mem [8192];
	int         watchdog_cycles = 0;

	video_top dut_i (.*);

	always #5 i_clock = ~i_clock;

	// ==================================================================
	// VRAM model
	// ==================================================================

	initial begin
		// Fill pattern, unique per word address.
		for (int i = 0; i < 8192; i++) begin
			vram_mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'h0BAD_F00D;
		end
	end

	// One ready pulse per request, after 1 to 4 cycles.
	initial begin : vram_model
		int unsigned latency;
		void'($urandom(32'ha06));
		forever begin
			@(negedge i_clock);
			if (i_rst_n && o_vram_request) begin
				latency = $urandom_range(4, 1);
				repeat (latency - 1) @(negedge i_clock);
				if (o_vram_rw) begin
					vram_mem[o_vram_address[14:2]] = o_vram_wdata;
				end else begin
					i_vram_rdata = vram_mem[o_vram_address[14:2]];
				end
				i_vram_ready = 1'b1;
				@(negedge i_clock);
				i_vram_ready = 1'b0;
			end
		end
	end

	// ==================================================================
	// Reference model of the picture
	// ==================================================================

	function automatic logic [7:0] index_at(input int pixel);
		return 8'(8'h30 + pixel * 5);
	endfunction

	function automatic logic [`VIDEO_RGB_W-1:0] colour_of(input logic [7:0] idx);
		return {idx, ~idx, idx ^ 8'h5a};
	endfunction

	function automatic vram_data_t row_word(input int word);
		return {index_at(4 * word + 3), index_at(4 * word + 2),
			index_at(4 * word + 1), index_at(4 * word)};
	endfunction

	// Border gives black, otherwise the palette colour of the selected byte.
	function automatic logic [`VIDEO_RGB_W-1:0] expected_rgb(input int x, input logic doubled);
		int word;
		int sel;
		if (x < SKIP_X || x >= `VIDEO_EXTENT - SKIP_X) begin
			return '0;
		end
		word = doubled ? (x / 8) - (SKIP_X / 8) : (x / 4) - (SKIP_X / 8);
		sel  = doubled ? (x / 2) % 4 : x % 4;
		return colour_of(index_at(word * 4 + sel));
	endfunction

	function automatic cpu_addr_u make_addr(input cpu_region_e region, input logic [23:0] location);
		cpu_addr_u addr;
		addr = '0;
		if (region == REGION_VRAM) begin
			addr.mem.offset = location;
		end else begin
			addr.csr.region = region;
			addr.csr.entry  = location[7:0];
		end
		return addr;
	endfunction

	// ==================================================================
	// Checks and drivers
	// ==================================================================

	task automatic check_data(input string name, input vram_data_t expected,
		input vram_data_t actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_rgb(input string name, input logic [`VIDEO_RGB_W-1:0] expected,
		input logic [`VIDEO_RGB_W-1:0] actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1, "colour mismatch");
		end
	endtask

	// Full request/ready cycle, returns the read data.
	task automatic cpu_access(input logic rw, input cpu_addr_u addr, input vram_data_t wdata,
		output vram_data_t rdata);
		i_cpu_request = 1'b1;
		i_cpu_rw      = rw;
		i_cpu_address = addr;
		i_cpu_wdata   = wdata;
		do @(negedge i_clock); while (!o_cpu_ready);
		rdata         = o_cpu_rdata;
		i_cpu_request = 1'b0;
		do @(negedge i_clock); while (o_cpu_ready);
	endtask

	task automatic pulse_vblank();
		i_video_vblank = 1'b1;
		repeat (3) @(negedge i_clock);
		i_video_vblank = 1'b0;
		repeat (3) @(negedge i_clock);
	endtask

	// Returns while the line fetch is still running.
	task automatic pulse_hblank();
		i_video_hblank = 1'b1;
		repeat (4) @(negedge i_clock);
		i_video_hblank = 1'b0;
		@(negedge i_clock);
	endtask

	task automatic add_step(input op_e op, input cpu_region_e region, input logic [23:0] location,
		input vram_data_t data, input vram_data_t expected);
		steps.push_back({op, region, location, data, expected});
	endtask

	task automatic build_table();
		// Control registers.
		add_step(OP_WRITE, REGION_REGS, REG_READ_OFFSET, READ_OFFSET, 0);
		add_step(OP_WRITE, REGION_REGS, REG_PITCH, PITCH, 0);
		add_step(OP_WRITE, REGION_REGS, REG_SKIP_MODE, 2, 0);
		add_step(OP_WRITE, REGION_REGS, REG_SKIP_X, SKIP_X, 0);
		add_step(OP_WRITE, REGION_REGS, REG_SKIP_Y, SKIP_Y, 0);
		add_step(OP_READ, REGION_REGS, REG_READ_OFFSET, 0, READ_OFFSET);
		add_step(OP_READ, REGION_REGS, REG_PITCH, 0, PITCH);
		add_step(OP_READ, REGION_REGS, REG_SKIP_MODE, 0, 2);
		add_step(OP_READ, REGION_REGS, REG_SKIP_X, 0, SKIP_X);
		add_step(OP_READ, REGION_REGS, REG_SKIP_Y, 0, SKIP_Y);
		// Plain VRAM round trip.
		add_step(OP_WRITE, REGION_VRAM, 24'h001230, 32'h1234_5678, 0);
		add_step(OP_READ, REGION_VRAM, 24'h001230, 0, 32'h1234_5678);
		for (int p = 0; p < 4 * ROW_WORDS; p++) begin
			add_step(OP_WRITE, REGION_PALETTE, index_at(p), colour_of(index_at(p)), 0);
		end
		add_step(OP_READ, REGION_PALETTE, index_at(0), 0, 0);
		// No doubling and no Y border, so row 0 is fetched.
		add_step(OP_WRITE, REGION_REGS, REG_SKIP_MODE, 0, 0);
		add_step(OP_WRITE, REGION_REGS, REG_SKIP_Y, 0, 0);
		add_step(OP_VBLANK, REGION_VRAM, 0, 0, 0);
		add_step(OP_READ, REGION_REGS, REG_FRAME_COUNT, 0, 1);
		add_step(OP_WRITE, REGION_REGS, REG_FRAME_COUNT, 7, 0);
		add_step(OP_READ, REGION_REGS, REG_FRAME_COUNT, 0, 1);
		for (int w = 0; w < ROW_WORDS; w++) begin
			add_step(OP_WRITE, REGION_VRAM, READ_OFFSET[23:0] + 24'(4 * w), row_word(w), 0);
		end
		// This read queues behind the row burst.
		add_step(OP_HBLANK, REGION_VRAM, 0, 0, 0);
		add_step(OP_READ, REGION_VRAM, READ_OFFSET[23:0] + 24'd8, 0, row_word(2));
	endtask

	// Step X across the first words and the right border.
	task automatic scan_line(input logic doubled);
		int last;
		last = doubled ? 39 : 19;
		for (int x = 0; x < `VIDEO_EXTENT; x++) begin
			if (x <= last || x >= `VIDEO_EXTENT - SKIP_X) begin
				i_video_pos_x = x;
				repeat (2) @(negedge i_clock);
				check_rgb($sformatf("scan x=%0d doubled=%0d", x, doubled),
					expected_rgb(x, doubled), o_video_rgb);
			end
		end
	endtask

	initial begin
		step_t      s;
		vram_data_t rdata;
		i_clock        = 1'b0;
		i_rst_n        = 1'b0;
		i_cpu_request  = 1'b0;
		i_cpu_rw       = 1'b0;
		i_cpu_address  = '0;
		i_cpu_wdata    = '0;
		i_video_hblank = 1'b0;
		i_video_vblank = 1'b0;
		i_video_pos_x  = '0;
		i_video_pos_y  = 11'd10;
		i_vram_rdata   = '0;
		i_vram_ready   = 1'b0;
		build_table();
		watchdog_cycles = steps.size() * 200 + 4000;
		repeat (2) @(negedge i_clock);
		i_rst_n = 1'b1;
		foreach (steps[i]) begin
			s = steps[i];
			case (s.op)
				OP_VBLANK: pulse_vblank();
				OP_HBLANK: pulse_hblank();
				default: begin
					cpu_access(s.op == OP_WRITE, make_addr(s.region, s.location), s.data, rdata);
					if (s.op == OP_READ) begin
						check_data($sformatf("step %0d region %h index %h", i, s.region,
							s.location), s.expected, rdata);
					end
				end
			endcase
		end
		scan_line(1'b0);
		cpu_access(1'b1, make_addr(REGION_REGS, REG_SKIP_MODE), 1, rdata);
		scan_line(1'b1);
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge i_clock);
		$display("Timeout: the DUT did not respond within %0d cycles", watchdog_cycles);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: verif/video_sva.sv
// Handshake assertions

`timescale 1ns/1ps

module video_sva import vram_bus_pkg::*; (
	input logic       i_clock,
	input logic       i_rst_n,
	input logic       i_cpu_request,
	input logic       i_cpu_ready,
	input logic       i_vram_request,
	input logic       i_vram_rw,
	input vram_addr_t i_vram_address,
	input vram_data_t i_vram_wdata,
	input logic       i_vram_ready
);

	// CPU ready holds while the request is up.
	cpu_ready_held: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_cpu_ready && i_cpu_request |=> i_cpu_ready)
		else $error("CPU ready dropped while the request was still high");

	// Ready falls once the request has fallen.
	cpu_ready_release: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_cpu_ready && !i_cpu_request |=> !i_cpu_ready)
		else $error("CPU ready stayed high after the request fell");

	// VRAM request and fields stay put until ready.
	vram_req_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_vram_request && !i_vram_ready |=>
			i_vram_request && $stable(i_vram_rw) && $stable(i_vram_address) &&
			$stable(i_vram_wdata))
		else $error("VRAM request changed before ready");

endmodule

bind video_top video_sva sva_i (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_cpu_request(i_cpu_request),
	.i_cpu_ready(o_cpu_ready),
	.i_vram_request(o_vram_request),
	.i_vram_rw(o_vram_rw),
	.i_vram_address(o_vram_address),
	.i_vram_wdata(o_vram_wdata),
	.i_vram_ready(i_vram_ready)
);

// File: rtl/video_top.sv
// Video controller top

`timescale 1ns/1ps
`include "video_macros.svh"

module video_top import video_regs_pkg::*, vram_bus_pkg::*; (
	input  logic                     i_clock,
	input  logic                     i_rst_n,
	input  logic                     i_cpu_request,
	input  logic                     i_cpu_rw,
	input  logic [`VIDEO_DATA_W-1:0] i_cpu_address,
	input  logic [`VIDEO_DATA_W-1:0] i_cpu_wdata,
	output logic [`VIDEO_DATA_W-1:0] o_cpu_rdata,
	output logic                     o_cpu_ready,
	input  logic                     i_video_hblank,
	input  logic                     i_video_vblank,
	input  logic [`VIDEO_POS_W-1:0]  i_video_pos_x,
	input  logic [`VIDEO_POS_W-1:0]  i_video_pos_y,
	output logic [`VIDEO_RGB_W-1:0]  o_video_rgb,
	output logic                     o_vram_request,
	output logic                     o_vram_rw,
	output vram_addr_t               o_vram_address,
	output vram_data_t               o_vram_wdata,
	input  vram_data_t               i_vram_rdata,
	input  logic                     i_vram_ready
);

	// ==================================================================
	// Internal nets
	// ==================================================================

	logic                      cpu_vram_req, cpu_vram_rw, cpu_vram_ready;
	vram_addr_t                cpu_vram_addr;
	vram_data_t                cpu_vram_wdata, cpu_vram_rdata;
	logic                      fetch_req, fetch_ready;
	vram_addr_t                fetch_addr;
	vram_data_t                fetch_rdata;
	logic                      pal_wr_en;
	logic [7:0]                pal_wr_addr, pal_rd_addr;
	logic [`VIDEO_RGB_W-1:0]   pal_wr_data, pal_rd_data;
	logic                      line_wr_en;
	logic [`VIDEO_LINE_AW-1:0] line_wr_addr, line_rd_addr;
	logic [`VIDEO_DATA_W-1:0]  line_wr_data, line_rd_data;
	logic [`VIDEO_DATA_W-1:0]  frame_count, read_offset, pitch;
	skip_mode_t                skip_mode;
	logic [`VIDEO_POS_W-1:0]   skip_x, skip_y;

	video_cpu_ctrl ctrl_i (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_cpu_request(i_cpu_request), .i_cpu_rw(i_cpu_rw),
		.i_cpu_address(i_cpu_address), .i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata), .o_cpu_ready(o_cpu_ready),
		.o_vram_req(cpu_vram_req), .o_vram_rw(cpu_vram_rw),
		.o_vram_addr(cpu_vram_addr), .o_vram_wdata(cpu_vram_wdata),
		.i_vram_rdata(cpu_vram_rdata), .i_vram_ready(cpu_vram_ready),
		.o_pal_wr_en(pal_wr_en), .o_pal_wr_addr(pal_wr_addr), .o_pal_wr_data(pal_wr_data),
		.i_frame_count(frame_count), .o_read_offset(read_offset), .o_pitch(pitch),
		.o_skip_mode(skip_mode), .o_skip_x(skip_x), .o_skip_y(skip_y)
	);

	vram_arbiter arbiter_i (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_fetch_req(fetch_req), .i_fetch_addr(fetch_addr),
		.o_fetch_rdata(fetch_rdata), .o_fetch_ready(fetch_ready),
		.i_cpu_req(cpu_vram_req), .i_cpu_rw(cpu_vram_rw), .i_cpu_addr(cpu_vram_addr),
		.i_cpu_wdata(cpu_vram_wdata), .o_cpu_rdata(cpu_vram_rdata),
		.o_cpu_ready(cpu_vram_ready),
		.o_vram_request(o_vram_request), .o_vram_rw(o_vram_rw),
		.o_vram_address(o_vram_address), .o_vram_wdata(o_vram_wdata),
		.i_vram_rdata(i_vram_rdata), .i_vram_ready(i_vram_ready)
	);

	video_line_fetch fetch_i (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_video_hblank(i_video_hblank), .i_video_vblank(i_video_vblank),
		.i_read_offset(read_offset), .i_pitch(pitch),
		.i_skip_mode(skip_mode), .i_skip_y(skip_y),
		.o_fetch_req(fetch_req), .o_fetch_addr(fetch_addr),
		.i_fetch_rdata(fetch_rdata), .i_fetch_ready(fetch_ready),
		.o_line_wr_en(line_wr_en), .o_line_wr_addr(line_wr_addr),
		.o_line_wr_data(line_wr_data), .o_frame_count(frame_count)
	);

	video_scanout scanout_i (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_pos_x(i_video_pos_x), .i_pos_y(i_video_pos_y),
		.i_skip_mode(skip_mode), .i_skip_x(skip_x), .i_skip_y(skip_y),
		.o_line_rd_addr(line_rd_addr), .i_line_rd_data(line_rd_data),
		.o_pal_rd_addr(pal_rd_addr), .i_pal_rd_data(pal_rd_data),
		.o_rgb(o_video_rgb)
	);

	// 256 colours of 24 bits.
	video_dp_ram #(.DEPTH(256), .WIDTH(`VIDEO_RGB_W)) palette_ram_i (
		.i_clock(i_clock),
		.i_wr_en(pal_wr_en), .i_wr_addr(pal_wr_addr), .i_wr_data(pal_wr_data),
		.i_rd_addr(pal_rd_addr), .o_rd_data(pal_rd_data)
	);

	// One line of pixel indices.
	video_dp_ram #(.DEPTH(`VIDEO_LINE_WORDS), .WIDTH(`VIDEO_DATA_W)) line_ram_i (
		.i_clock(i_clock),
		.i_wr_en(line_wr_en), .i_wr_addr(line_wr_addr), .i_wr_data(line_wr_data),
		.i_rd_addr(line_rd_addr), .o_rd_data(line_rd_data)
	);

endmodule

// File: rtl/video_scanout.sv
// Pixel scan-out

`timescale 1ns/1ps
`include "video_macros.svh"

module video_scanout import video_regs_pkg::*; (
	input  logic                      i_clock,
	input  logic                      i_rst_n,
	input  logic [`VIDEO_POS_W-1:0]   i_pos_x,
	input  logic [`VIDEO_POS_W-1:0]   i_pos_y,
	input  skip_mode_t                i_skip_mode,
	input  logic [`VIDEO_POS_W-1:0]   i_skip_x,
	input  logic [`VIDEO_POS_W-1:0]   i_skip_y,
	output logic [`VIDEO_LINE_AW-1:0] o_line_rd_addr,
	input  logic [`VIDEO_DATA_W-1:0]  i_line_rd_data,
	output logic [7:0]                o_pal_rd_addr,
	input  logic [`VIDEO_RGB_W-1:0]   i_pal_rd_data,
	output logic [`VIDEO_RGB_W-1:0]   o_rgb
);

	logic [`VIDEO_POS_W-3:0] word_idx;
	logic [1:0]              byte_sel;
	logic [1:0]              sel_q;
	logic                    in_window;
	logic [1:0]              win_q;

	assign in_window =
		(i_pos_x >= i_skip_x) && (i_pos_x < `VIDEO_POS_W'(`VIDEO_EXTENT) - i_skip_x) &&
		(i_pos_y >= i_skip_y) && (i_pos_y < `VIDEO_POS_W'(`VIDEO_EXTENT) - i_skip_y);

	// Four pixels per word, eight when doubled.
	always_comb begin
		if (i_skip_mode[0]) begin
			word_idx = {1'b0, i_pos_x[`VIDEO_POS_W-1:3]} - {1'b0, i_skip_x[`VIDEO_POS_W-1:3]};
			byte_sel = i_pos_x[2:1];
		end else begin
			word_idx = i_pos_x[`VIDEO_POS_W-1:2] - {1'b0, i_skip_x[`VIDEO_POS_W-1:3]};
			byte_sel = i_pos_x[1:0];
		end
	end

	assign o_line_rd_addr = word_idx[`VIDEO_LINE_AW-1:0];
	assign o_pal_rd_addr  = i_line_rd_data[{sel_q, 3'b000} +: 8];

	// Byte select follows the line read, the window flag both reads.
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sel_q <= '0;
			win_q <= '0;
		end else begin
			sel_q <= byte_sel;
			win_q <= {win_q[0], in_window};
		end
	end

	assign o_rgb = win_q[1] ? i_pal_rd_data : '0;

endmodule

// File: rtl/video_line_fetch.sv
// Line fetcher

`timescale 1ns/1ps
`include "video_macros.svh"

module video_line_fetch import video_regs_pkg::*, vram_bus_pkg::*; (
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  logic                        i_video_hblank,
	input  logic                        i_video_vblank,
	input  logic [`VIDEO_DATA_W-1:0]    i_read_offset,
	input  logic [`VIDEO_DATA_W-1:0]    i_pitch,
	input  skip_mode_t                  i_skip_mode,
	input  logic [`VIDEO_POS_W-1:0]     i_skip_y,
	output logic                        o_fetch_req,
	output vram_addr_t                  o_fetch_addr,
	input  vram_data_t                  i_fetch_rdata,
	input  logic                        i_fetch_ready,
	output logic                        o_line_wr_en,
	output logic [`VIDEO_LINE_AW-1:0]   o_line_wr_addr,
	output logic [`VIDEO_DATA_W-1:0]    o_line_wr_data,
	output logic [`VIDEO_DATA_W-1:0]    o_frame_count
);

	logic [1:0]                hs;
	logic [1:0]                vs;
	logic [`VIDEO_POS_W-1:0]   row_num;
	logic [`VIDEO_POS_W-1:0]   y_limit;
	logic [`VIDEO_DATA_W-1:0]  row_offset;
	logic [`VIDEO_LINE_AW-1:0] column;
	logic                      row_ok;
	logic                      start;
	logic                      word_done;
	logic                      last_word;

	assign y_limit   = `VIDEO_POS_W'(`VIDEO_EXTENT) - i_skip_y;
	// Inside the Y window, odd rows only when lines are doubled.
	assign row_ok    = (row_num >= i_skip_y) && (row_num < y_limit) &&
		(!i_skip_mode[1] || row_num[0]);
	assign start     = (hs == 2'b01) && (vs == 2'b00) && row_ok;
	assign word_done = o_fetch_req && i_fetch_ready;
	assign last_word = (vram_data_t'(column) + 1'b1) >= (i_pitch >> 2);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hs            <= '0;
			vs            <= '0;
			row_num       <= '0;
			row_offset    <= '0;
			column        <= '0;
			o_frame_count <= '0;
			o_fetch_req   <= 1'b0;
			o_line_wr_en  <= 1'b0;
		end else begin
			hs           <= {hs[0], i_video_hblank};
			vs           <= {vs[0], i_video_vblank};
			o_line_wr_en <= word_done;
			// New frame.
			if (vs == 2'b01) begin
				row_num       <= '0;
				row_offset    <= '0;
				o_frame_count <= o_frame_count + 1'b1;
			end
			if (hs == 2'b01 && vs == 2'b00) begin
				row_num <= row_num + 1'b1;
			end
			if (word_done) begin
				column <= column + 1'b1;
				if (last_word) begin
					o_fetch_req <= 1'b0;
				end
			end
			if (start) begin
				column      <= '0;
				row_offset  <= row_offset + i_pitch;
				o_fetch_req <= 1'b1;
			end
		end
	end

	// Burst address and line buffer data.
	always_ff @(posedge i_clock) begin
		if (start) begin
			o_fetch_addr <= i_read_offset + row_offset;
		end else if (word_done) begin
			o_fetch_addr <= o_fetch_addr + 3'd4;
		end
		if (word_done) begin
			o_line_wr_addr <= column;
			o_line_wr_data <= i_fetch_rdata;
		end
	end

endmodule

// File: rtl/vram_arbiter.sv
// VRAM port arbiter

`timescale 1ns/1ps

module vram_arbiter import vram_bus_pkg::*; (
	input  logic       i_clock,
	input  logic       i_rst_n,
	input  logic       i_fetch_req,
	input  vram_addr_t i_fetch_addr,
	output vram_data_t o_fetch_rdata,
	output logic       o_fetch_ready,
	input  logic       i_cpu_req,
	input  logic       i_cpu_rw,
	input  vram_addr_t i_cpu_addr,
	input  vram_data_t i_cpu_wdata,
	output vram_data_t o_cpu_rdata,
	output logic       o_cpu_ready,
	output logic       o_vram_request,
	output logic       o_vram_rw,
	output vram_addr_t o_vram_address,
	output vram_data_t o_vram_wdata,
	input  vram_data_t i_vram_rdata,
	input  logic       i_vram_ready
);

	vram_grant_e grant;

	// Fetch wins a tie, an owner keeps the port until its ready.
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			grant <= GRANT_NONE;
		end else if (grant == GRANT_NONE) begin
			if (i_fetch_req) begin
				grant <= GRANT_FETCH;
			end else if (i_cpu_req) begin
				grant <= GRANT_CPU;
			end
		end else if (i_vram_ready) begin
			grant <= GRANT_NONE;
		end
	end

	// Owner onto the VRAM port.
	always_comb begin
		case (grant)
			GRANT_FETCH: begin
				o_vram_request = i_fetch_req;
				o_vram_rw      = 1'b0;
				o_vram_address = i_fetch_addr;
				o_vram_wdata   = '0;
			end
			GRANT_CPU: begin
				o_vram_request = i_cpu_req;
				o_vram_rw      = i_cpu_rw;
				o_vram_address = i_cpu_addr;
				o_vram_wdata   = i_cpu_wdata;
			end
			default: begin
				o_vram_request = 1'b0;
				o_vram_rw      = 1'b0;
				o_vram_address = '0;
				o_vram_wdata   = '0;
			end
		endcase
	end

	// Responses go back to the owner only.
	assign o_fetch_ready = (grant == GRANT_FETCH) && i_vram_ready;
	assign o_cpu_ready   = (grant == GRANT_CPU) && i_vram_ready;
	assign o_fetch_rdata = (grant == GRANT_FETCH) ? i_vram_rdata : '0;
	assign o_cpu_rdata   = (grant == GRANT_CPU) ? i_vram_rdata : '0;

endmodule

// File: rtl/video_cpu_ctrl.sv
// CPU access controller

`timescale 1ns/1ps
`include "video_macros.svh"

module video_cpu_ctrl import video_regs_pkg::*, vram_bus_pkg::*; (
	input  logic                        i_clock,
	input  logic                        i_rst_n,
	input  logic                        i_cpu_request,
	input  logic                        i_cpu_rw,
	input  cpu_addr_u                   i_cpu_address,
	input  logic [`VIDEO_DATA_W-1:0]    i_cpu_wdata,
	output logic [`VIDEO_DATA_W-1:0]    o_cpu_rdata,
	output logic                        o_cpu_ready,
	output logic                        o_vram_req,
	output logic                        o_vram_rw,
	output vram_addr_t                  o_vram_addr,
	output vram_data_t                  o_vram_wdata,
	input  vram_data_t                  i_vram_rdata,
	input  logic                        i_vram_ready,
	output logic                        o_pal_wr_en,
	output logic [7:0]                  o_pal_wr_addr,
	output logic [`VIDEO_RGB_W-1:0]     o_pal_wr_data,
	input  logic [`VIDEO_DATA_W-1:0]    i_frame_count,
	output logic [`VIDEO_DATA_W-1:0]    o_read_offset,
	output logic [`VIDEO_DATA_W-1:0]    o_pitch,
	output skip_mode_t                  o_skip_mode,
	output logic [`VIDEO_POS_W-1:0]     o_skip_x,
	output logic [`VIDEO_POS_W-1:0]     o_skip_y
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_VRAM_WAIT,
		ST_PALETTE,
		ST_REGISTER,
		ST_RELEASE
	} state_e;

	state_e                   state;
	cpu_addr_u                addr_q;
	logic                     rw_q;
	logic [`VIDEO_DATA_W-1:0] wdata_q;
	ctrl_reg_e                reg_idx;
	logic [`VIDEO_DATA_W-1:0] reg_rdata;

	// Request fields, captured when leaving idle.
	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE && i_cpu_request) begin
			addr_q  <= i_cpu_address;
			rw_q    <= i_cpu_rw;
			wdata_q <= i_cpu_wdata;
		end
	end

	assign o_vram_rw    = rw_q;
	assign o_vram_addr  = vram_addr_t'({8'h00, addr_q.mem.offset});
	assign o_vram_wdata = wdata_q;

	// Palette write lasts the single palette cycle.
	assign o_pal_wr_en   = (state == ST_PALETTE) && rw_q;
	assign o_pal_wr_addr = addr_q.csr.entry;
	assign o_pal_wr_data = wdata_q[`VIDEO_RGB_W-1:0];

	assign reg_idx = ctrl_reg_e'(addr_q.csr.entry[2:0]);

	// Register read mux.
	always_comb begin
		case (reg_idx)
			REG_READ_OFFSET: reg_rdata = o_read_offset;
			REG_PITCH:       reg_rdata = o_pitch;
			REG_SKIP_MODE:   reg_rdata = `VIDEO_DATA_W'(o_skip_mode);
			REG_SKIP_X:      reg_rdata = `VIDEO_DATA_W'(o_skip_x);
			REG_SKIP_Y:      reg_rdata = `VIDEO_DATA_W'(o_skip_y);
			REG_FRAME_COUNT: reg_rdata = i_frame_count;
			default:         reg_rdata = '0;
		endcase
	end

	// ==================================================================
	// Access sequencer
	// ==================================================================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= ST_IDLE;
			o_cpu_ready   <= 1'b0;
			o_cpu_rdata   <= '0;
			o_vram_req    <= 1'b0;
			o_read_offset <= '0;
			o_pitch       <= `VIDEO_DATA_W'(`VIDEO_MAX_PITCH);
			o_skip_mode   <= '0;
			o_skip_x      <= '0;
			o_skip_y      <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_cpu_request) begin
						case (i_cpu_address.csr.region)
							REGION_PALETTE: state <= ST_PALETTE;
							REGION_REGS:    state <= ST_REGISTER;
							default: begin
								o_vram_req <= 1'b1;
								state      <= ST_VRAM_WAIT;
							end
						endcase
					end
				end
				ST_VRAM_WAIT: begin
					if (i_vram_ready) begin
						o_vram_req  <= 1'b0;
						o_cpu_rdata <= i_vram_rdata;
						o_cpu_ready <= 1'b1;
						state       <= ST_RELEASE;
					end
				end
				ST_PALETTE: begin
					o_cpu_rdata <= '0;
					o_cpu_ready <= 1'b1;
					state       <= ST_RELEASE;
				end
				ST_REGISTER: begin
					if (rw_q) begin
						case (reg_idx)
							REG_READ_OFFSET: o_read_offset <= wdata_q;
							REG_PITCH:       o_pitch       <= wdata_q;
							REG_SKIP_MODE:   o_skip_mode   <= wdata_q[1:0];
							REG_SKIP_X:      o_skip_x      <= wdata_q[`VIDEO_POS_W-1:0];
							REG_SKIP_Y:      o_skip_y      <= wdata_q[`VIDEO_POS_W-1:0];
							default:         ;
						endcase
					end
					o_cpu_rdata <= rw_q ? '0 : reg_rdata;
					o_cpu_ready <= 1'b1;
					state       <= ST_RELEASE;
				end
				// Hold ready until the CPU lets go.
				ST_RELEASE: begin
					o_cpu_ready <= i_cpu_request;
					if (!i_cpu_request) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/video_dp_ram.sv
// Simple dual port RAM

`timescale 1ns/1ps

module video_dp_ram #(
	parameter int DEPTH = 256,
	parameter int WIDTH = 24
) (
	input  logic                     i_clock,
	input  logic                     i_wr_en,
	input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
	input  logic [WIDTH-1:0]         i_wr_data,
	input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
	output logic [WIDTH-1:0]         o_rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Write port.
	always_ff @(posedge i_clock) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// Registered read, one cycle latency.
	always_ff @(posedge i_clock) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// File: rtl/vram_bus_pkg.sv
// VRAM bus types

package vram_bus_pkg;

	`include "video_macros.svh"

	typedef logic [`VIDEO_DATA_W-1:0] vram_addr_t;
	typedef logic [`VIDEO_DATA_W-1:0] vram_data_t;

	// Current owner of the VRAM port.
	typedef enum logic [1:0] {
		GRANT_NONE  = 2'd0,
		GRANT_FETCH = 2'd1,
		GRANT_CPU   = 2'd2
	} vram_grant_e;

endpackage

// File: rtl/video_regs_pkg.sv
// Register side types

package video_regs_pkg;

	// Top nibble of the CPU offset.
	// Values other than E and F go to VRAM.
	typedef enum logic [3:0] {
		REGION_VRAM    = 4'h0,
		REGION_PALETTE = 4'hE,
		REGION_REGS    = 4'hF
	} cpu_region_e;

	// Control register index.
	typedef enum logic [2:0] {
		REG_READ_OFFSET = 3'd0,
		REG_PITCH       = 3'd1,
		REG_SKIP_MODE   = 3'd2,
		REG_SKIP_X      = 3'd3,
		REG_SKIP_Y      = 3'd4,
		REG_FRAME_COUNT = 3'd5
	} ctrl_reg_e;

	// Bit 0 doubles pixels, bit 1 doubles lines.
	typedef logic [1:0] skip_mode_t;

	// CPU address, seen as a VRAM offset or as a palette/register index.
	typedef union packed {
		struct packed {
			logic [7:0]  unused;
			logic [23:0] offset;
		} mem;
		struct packed {
			logic [7:0]  unused_hi;
			cpu_region_e region;
			logic [9:0]  unused_lo;
			logic [7:0]  entry;
			logic [1:0]  byte_sel;
		} csr;
	} cpu_addr_u;

endpackage

// File: rtl/video_macros.svh
// Video controller constants

`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Bus word width.
`define VIDEO_DATA_W 32

// Beam position width.
`define VIDEO_POS_W 11

// Visible extent on both axes.
`define VIDEO_EXTENT 720

// Longest line in bytes, and the line buffer shape.
`define VIDEO_MAX_PITCH 640
`define VIDEO_LINE_WORDS (`VIDEO_MAX_PITCH / 4)
`define VIDEO_LINE_AW $clog2(`VIDEO_LINE_WORDS)

// Colour width.
`define VIDEO_RGB_W 24

`endif
